/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_ppc_core
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
design/ppc_pkg.sv
design/operand_if.sv
design/instr_decode.sv
design/gp_reg_file.sv
design/issue_fsm.sv
design/mul_step_counter.sv
design/add_log_unit.sv
design/mul_unit.sv
design/ppc_core.sv
testbench/tb_ppc_core.sv

/* design/add_log_unit.sv */
////////////////////
// Add and logic unit
// Single cycle, result registered on issue
////////////////////
`timescale 1ns/100ps
`default_nettype none

module add_log_unit (
    input logic clk,
    input logic rst,
    operand_if.unit oper,
    output logic [0:ppc_pkg::xlen-1] alu_result
);

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_result <= '0;
        end else if (oper.issue) begin
            case (oper.op)
                ppc_pkg::op_add: alu_result <= oper.op_a + oper.op_b;
                // subf is rb minus ra
                ppc_pkg::op_subf: alu_result <= oper.op_b - oper.op_a;
                ppc_pkg::op_and: alu_result <= oper.op_a & oper.op_b;
                ppc_pkg::op_or: alu_result <= oper.op_a | oper.op_b;
                ppc_pkg::op_xor: alu_result <= oper.op_a ^ oper.op_b;
                default: alu_result <= alu_result;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/gp_reg_file.sv */
////////////////////
// General purpose registers
// Two read ports, one write port
////////////////////
`timescale 1ns/100ps
`default_nettype none

module gp_reg_file (
    input logic clk,
    input logic rst,
    input logic [0:ppc_pkg::reg_addr_width-1] read_addr_a,
    input logic [0:ppc_pkg::reg_addr_width-1] read_addr_b,
    input logic write_enable,
    input logic [0:ppc_pkg::reg_addr_width-1] write_addr,
    input logic [0:ppc_pkg::xlen-1] write_value,
    output logic [0:ppc_pkg::xlen-1] read_value_a,
    output logic [0:ppc_pkg::xlen-1] read_value_b
);

    logic [0:ppc_pkg::xlen-1] regs [0:ppc_pkg::num_gprs-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ppc_pkg::num_gprs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable) begin
            regs[write_addr] <= write_value;
        end
    end

    assign read_value_a = regs[read_addr_a];
    assign read_value_b = regs[read_addr_b];

endmodule

`default_nettype wire

/* design/instr_decode.sv */
////////////////////
// Instruction decode
// Registers the word and selects operation and operands
////////////////////
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
    input logic clk,
    input logic rst,
    input logic load,
    input logic [0:ppc_pkg::xlen-1] instruction,
    output ppc_pkg::fx_op_t op,
    output logic [0:ppc_pkg::reg_addr_width-1] rt,
    output logic [0:ppc_pkg::reg_addr_width-1] ra,
    output logic [0:ppc_pkg::reg_addr_width-1] rb,
    output logic [0:ppc_pkg::xlen-1] imm,
    output logic use_imm
);

    ppc_pkg::instr_word_u word;

    // Cleared word has opcode 0 and decodes as illegal
    always_ff @(posedge clk) begin
        if (rst) begin
            word <= '0;
        end else if (load) begin
            word <= instruction;
        end
    end

    assign rt = word.x_form.rt;
    assign ra = word.x_form.ra;
    assign rb = word.x_form.rb;
    assign imm = {{(ppc_pkg::xlen - 16){word.d_form.simm[0]}}, word.d_form.simm};
    assign use_imm = (word.d_form.opcd == ppc_pkg::opcode_addi);

    always_comb begin
        op = ppc_pkg::op_illegal;
        if (word.d_form.opcd == ppc_pkg::opcode_addi) begin
            op = ppc_pkg::op_add;
        end else if (word.x_form.opcd == ppc_pkg::opcode_x) begin
            case (word.x_form.xo)
                ppc_pkg::xo_and: op = ppc_pkg::op_and;
                ppc_pkg::xo_or: op = ppc_pkg::op_or;
                ppc_pkg::xo_xor: op = ppc_pkg::op_xor;
                default: begin
                    // XO-form, OE bit in xo[0] is ignored
                    case (word.x_form.xo[1:9])
                        ppc_pkg::xo_add[1:9]: op = ppc_pkg::op_add;
                        ppc_pkg::xo_subf[1:9]: op = ppc_pkg::op_subf;
                        ppc_pkg::xo_mullw[1:9]: op = ppc_pkg::op_mul;
                        default: op = ppc_pkg::op_illegal;
                    endcase
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/issue_fsm.sv */
////////////////////
// Issue controller
// One instruction from accept to write-back
////////////////////
`timescale 1ns/100ps
`default_nettype none

module issue_fsm (
    input logic clk,
    input logic rst,
    input logic instruction_valid,
    input ppc_pkg::fx_op_t op,
    input logic [0:ppc_pkg::reg_addr_width-1] ra,
    input logic use_imm,
    input logic [0:ppc_pkg::xlen-1] imm,
    input logic [0:ppc_pkg::xlen-1] read_value_a,
    input logic [0:ppc_pkg::xlen-1] read_value_b,
    input logic [0:ppc_pkg::xlen-1] alu_result,
    input logic [0:ppc_pkg::xlen-1] mul_result,
    input logic count_last,
    input logic result_ready,
    output logic instruction_ready,
    output logic decode_load,
    output logic count_start,
    output logic result_valid,
    output logic [0:ppc_pkg::xlen-1] result,
    operand_if.issuer oper
);

    typedef enum logic [1:0] {idle, read, exec_mul, write_back} state_t;

    state_t state;
    logic capture;

    assign instruction_ready = (state == idle);
    assign decode_load = instruction_valid & instruction_ready;
    // Unit result is registered one cycle after issue
    assign capture = (state == write_back) & ~result_valid & ~oper.issue;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            oper.issue <= 1'b0;
            count_start <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            oper.issue <= 1'b0;
            count_start <= 1'b0;
            case (state)
                idle: begin
                    if (decode_load) begin
                        state <= read;
                    end
                end
                read: begin
                    if (op == ppc_pkg::op_illegal) begin
                        state <= idle;
                    end else if (op == ppc_pkg::op_mul) begin
                        oper.issue <= 1'b1;
                        count_start <= 1'b1;
                        state <= exec_mul;
                    end else begin
                        oper.issue <= 1'b1;
                        state <= write_back;
                    end
                end
                exec_mul: begin
                    if (count_last) begin
                        state <= write_back;
                    end
                end
                write_back: begin
                    if (capture) begin
                        result_valid <= 1'b1;
                    end else if (result_valid && result_ready) begin
                        result_valid <= 1'b0;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Operand registers and held result
    always_ff @(posedge clk) begin
        if (state == read) begin
            oper.op <= op;
            oper.op_a <= (use_imm && ra == '0) ? '0 : read_value_a;
            oper.op_b <= use_imm ? imm : read_value_b;
        end
        if (capture) begin
            result <= (oper.op == ppc_pkg::op_mul) ? mul_result : alu_result;
        end
    end

endmodule

`default_nettype wire

/* design/mul_step_counter.sv */
////////////////////
// Multiplier step counter
////////////////////
`timescale 1ns/100ps
`default_nettype none

module mul_step_counter #(
    parameter int STEPS = 32
) (
    input logic clk,
    input logic rst,
    input logic count_start,
    output logic count_busy,
    output logic count_last
);

    localparam int CW = $clog2(STEPS + 1);

    logic [0:CW-1] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (count_start) begin
            count <= CW'(STEPS);
        end else if (count_busy) begin
            count <= count - 1'b1;
        end
    end

    assign count_busy = (count != '0);
    assign count_last = (count == CW'(1));

endmodule

`default_nettype wire

/* design/mul_unit.sv */
////////////////////
// Shift-add multiplier
// Keeps the low XLEN bits of the product
////////////////////
`timescale 1ns/100ps
`default_nettype none

module mul_unit #(
    parameter int XLEN = 32
) (
    input logic clk,
    input logic rst,
    input logic count_busy,
    operand_if.unit oper,
    output logic [0:XLEN-1] mul_result
);

    logic [0:XLEN-1] multiplicand;
    logic [0:XLEN-1] multiplier;
    logic [0:XLEN-1] product;

    always_ff @(posedge clk) begin
        if (rst) begin
            product <= '0;
        end else if (oper.issue && oper.op == ppc_pkg::op_mul) begin
            multiplicand <= oper.op_a;
            multiplier <= oper.op_b;
            product <= '0;
        end else if (count_busy) begin
            // LSB sits at index XLEN-1
            if (multiplier[XLEN-1]) begin
                product <= product + multiplicand;
            end
            multiplicand <= multiplicand << 1;
            multiplier <= multiplier >> 1;
        end
    end

    assign mul_result = product;

endmodule

`default_nettype wire

/* design/operand_if.sv */
////////////////////
// Issued operands and operation for the execution units
////////////////////
`timescale 1ns/100ps
`default_nettype none

interface operand_if #(
    parameter int XLEN = ppc_pkg::xlen
) ();

    logic [0:XLEN-1] op_a;
    logic [0:XLEN-1] op_b;
    ppc_pkg::fx_op_t op;
    // High for one cycle per issued instruction
    logic issue;

    modport issuer (output op_a, output op_b, output op, output issue);

    modport unit (input op_a, input op_b, input op, input issue);

endinterface

`default_nettype wire

/* design/ppc_core.sv */
////////////////////
// Fixed-point core top level
// One instruction in flight, GPR write on result handshake
////////////////////
`timescale 1ns/100ps
`default_nettype none

module ppc_core #(
    parameter int XLEN = ppc_pkg::xlen
) (
    input logic clk,
    input logic rst,
    input logic instruction_valid,
    output logic instruction_ready,
    input logic [0:XLEN-1] instruction,
    output logic result_valid,
    input logic result_ready,
    output logic [0:ppc_pkg::reg_addr_width-1] result_reg_addr,
    output logic [0:XLEN-1] result
);

    logic decode_load;
    ppc_pkg::fx_op_t op;
    logic [0:ppc_pkg::reg_addr_width-1] ra;
    logic [0:ppc_pkg::reg_addr_width-1] rb;
    logic [0:XLEN-1] imm;
    logic use_imm;
    logic [0:XLEN-1] read_value_a;
    logic [0:XLEN-1] read_value_b;
    logic gpr_write_enable;
    logic [0:XLEN-1] alu_result;
    logic [0:XLEN-1] mul_result;
    logic count_start;
    logic count_busy;
    logic count_last;

    operand_if #(.XLEN(XLEN)) oper ();

    instr_decode i_instr_decode (
        .clk(clk),
        .rst(rst),
        .load(decode_load),
        .instruction(instruction),
        .op(op),
        .rt(result_reg_addr),
        .ra(ra),
        .rb(rb),
        .imm(imm),
        .use_imm(use_imm)
    );

    assign gpr_write_enable = result_valid & result_ready;

    gp_reg_file i_gp_reg_file (
        .clk(clk),
        .rst(rst),
        .read_addr_a(ra),
        .read_addr_b(rb),
        .write_enable(gpr_write_enable),
        .write_addr(result_reg_addr),
        .write_value(result),
        .read_value_a(read_value_a),
        .read_value_b(read_value_b)
    );

    issue_fsm i_issue_fsm (
        .clk(clk),
        .rst(rst),
        .instruction_valid(instruction_valid),
        .op(op),
        .ra(ra),
        .use_imm(use_imm),
        .imm(imm),
        .read_value_a(read_value_a),
        .read_value_b(read_value_b),
        .alu_result(alu_result),
        .mul_result(mul_result),
        .count_last(count_last),
        .result_ready(result_ready),
        .instruction_ready(instruction_ready),
        .decode_load(decode_load),
        .count_start(count_start),
        .result_valid(result_valid),
        .result(result),
        .oper(oper.issuer)
    );

    mul_step_counter #(.STEPS(XLEN)) i_mul_step_counter (
        .clk(clk),
        .rst(rst),
        .count_start(count_start),
        .count_busy(count_busy),
        .count_last(count_last)
    );

    add_log_unit i_add_log_unit (
        .clk(clk),
        .rst(rst),
        .oper(oper.unit),
        .alu_result(alu_result)
    );

    mul_unit #(.XLEN(XLEN)) i_mul_unit (
        .clk(clk),
        .rst(rst),
        .count_busy(count_busy),
        .oper(oper.unit),
        .mul_result(mul_result)
    );

endmodule

`default_nettype wire

/* design/ppc_pkg.sv */
////////////////////
// Shared definitions of the fixed-point core
// Widths, opcodes, operations and instruction formats
////////////////////
`default_nettype none

package ppc_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;
    localparam int num_gprs = 32;

    // Primary opcodes
    localparam logic [0:5] opcode_addi = 6'd14;
    localparam logic [0:5] opcode_x = 6'd31;

    // Extended opcodes, 10-bit view including the OE position
    localparam logic [0:9] xo_add = 10'd266;
    localparam logic [0:9] xo_subf = 10'd40;
    localparam logic [0:9] xo_and = 10'd28;
    localparam logic [0:9] xo_or = 10'd444;
    localparam logic [0:9] xo_xor = 10'd316;
    localparam logic [0:9] xo_mullw = 10'd235;

    typedef enum logic [2:0] {
        op_add,
        op_subf,
        op_and,
        op_or,
        op_xor,
        op_mul,
        op_illegal
    } fx_op_t;

    // One instruction word, seen as D-form or X/XO-form
    typedef union packed {
        struct packed {
            logic [0:5] opcd;
            logic [0:4] rt;
            logic [0:4] ra;
            logic [0:15] simm;
        } d_form;
        struct packed {
            logic [0:5] opcd;
            logic [0:4] rt;
            logic [0:4] ra;
            logic [0:4] rb;
            logic [0:9] xo;
            logic rc;
        } x_form;
    } instr_word_u;

endpackage

`default_nettype wire

/* testbench/tb_ppc_core.sv */
////////////////////
// Testbench of the fixed-point core
// Directed tests against a GPR model
////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_ppc_core;

    localparam int wait_limit = 100;

    logic clk;
    logic rst;
    logic instruction_valid;
    logic instruction_ready;
    logic [31:0] instruction;
    logic result_valid;
    logic result_ready;
    logic [4:0] result_reg_addr;
    logic [31:0] result;

    logic [31:0] gpr_model [0:31];
    integer seed;
    int stall_cycles;
    int last_latency;

    ppc_core #(.XLEN(ppc_pkg::xlen)) i_ppc_core (
        .clk(clk),
        .rst(rst),
        .instruction_valid(instruction_valid),
        .instruction_ready(instruction_ready),
        .instruction(instruction),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .result_reg_addr(result_reg_addr),
        .result(result)
    );

    always #20 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_on_error($sformatf("Fail %s: expected %h, actual %h",
                                    test_name, expected, actual));
        end
    endtask

    task automatic send_instruction(input logic [31:0] word);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!instruction_ready) begin
            if (cycles == wait_limit) begin
                stop_on_error("Timeout while waiting for instruction_ready");
            end
            @(negedge clk);
            cycles++;
        end
        instruction_valid = 1'b1;
        instruction = word;
        @(posedge clk);
        @(negedge clk);
        instruction_valid = 1'b0;
    endtask

    // Latency counts clock edges after the accepting edge
    task automatic execute(input string test_name, input logic [31:0] word,
                           input logic [4:0] rt, input logic [31:0] expected);
        last_latency = 0;
        send_instruction(word);
        while (!result_valid) begin
            if (last_latency == wait_limit) begin
                stop_on_error($sformatf("Timeout while waiting for result_valid in %s",
                                        test_name));
            end
            @(negedge clk);
            last_latency++;
        end
        check_value(test_name, expected, result);
        check_value({test_name, " addr"}, 32'(rt), 32'(result_reg_addr));
        repeat (stall_cycles) begin
            @(negedge clk);
            check_value({test_name, " held valid"}, 32'd1, 32'(result_valid));
            check_value({test_name, " held result"}, expected, result);
            check_value({test_name, " held addr"}, 32'(rt), 32'(result_reg_addr));
            check_value({test_name, " ready low"}, 32'd0, 32'(instruction_ready));
        end
        result_ready = 1'b1;
        @(posedge clk);
        @(negedge clk);
        result_ready = 1'b0;
        gpr_model[rt] = expected;
    endtask

    task automatic run_addi(input string test_name, input logic [4:0] rt,
                            input logic [4:0] ra, input logic [15:0] simm);
        logic [31:0] a;
        a = (ra == 5'd0) ? 32'd0 : gpr_model[ra];
        execute(test_name, {ppc_pkg::opcode_addi, rt, ra, simm}, rt,
                a + {{16{simm[15]}}, simm});
    endtask

    task automatic run_x_op(input string test_name, input logic [9:0] xo,
                            input logic [4:0] rt, input logic [4:0] ra, input logic [4:0] rb);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        a = gpr_model[ra];
        b = gpr_model[rb];
        case (xo)
            ppc_pkg::xo_add: expected = a + b;
            ppc_pkg::xo_subf: expected = b - a;
            ppc_pkg::xo_and: expected = a & b;
            ppc_pkg::xo_or: expected = a | b;
            ppc_pkg::xo_xor: expected = a ^ b;
            ppc_pkg::xo_mullw: expected = a * b;
            default: expected = 32'd0;
        endcase
        execute(test_name, {ppc_pkg::opcode_x, rt, ra, rb, xo, 1'b0}, rt, expected);
    endtask

    task automatic test_addi_after_reset();
        check_value("reset result_valid", 32'd0, 32'(result_valid));
        check_value("reset instruction_ready", 32'd1, 32'(instruction_ready));
        run_addi("addi ra0", 5'd1, 5'd0, 16'hfffb);
        check_value("addi latency", 32'd3, 32'(last_latency));
    endtask

    task automatic test_add_subf();
        run_addi("addi r2", 5'd2, 5'd0, 16'd1000);
        // Reads r2 back through the GPR file
        run_addi("addi r3", 5'd3, 5'd2, 16'h7000);
        run_x_op("add", ppc_pkg::xo_add, 5'd4, 5'd2, 5'd3);
        check_value("add latency", 32'd3, 32'(last_latency));
        run_x_op("subf", ppc_pkg::xo_subf, 5'd5, 5'd3, 5'd2);
    endtask

    task automatic test_logic_ops();
        repeat (4) begin
            run_addi("addi r6 random", 5'd6, 5'd0, 16'($random(seed)));
            run_addi("addi r7 random", 5'd7, 5'd0, 16'($random(seed)));
            run_x_op("and", ppc_pkg::xo_and, 5'd8, 5'd6, 5'd7);
            run_x_op("or", ppc_pkg::xo_or, 5'd9, 5'd6, 5'd5);
            run_x_op("xor", ppc_pkg::xo_xor, 5'd10, 5'd7, 5'd5);
        end
    endtask

    task automatic test_mullw();
        repeat (3) begin
            run_addi("addi r11 random", 5'd11, 5'd0, 16'($random(seed)));
            run_addi("addi r12 random", 5'd12, 5'd0, 16'($random(seed)));
            run_x_op("mullw", ppc_pkg::xo_mullw, 5'd13, 5'd11, 5'd12);
            run_x_op("mullw wide", ppc_pkg::xo_mullw, 5'd14, 5'd13, 5'd5);
        end
    endtask

    task automatic test_back_pressure();
        stall_cycles = 6;
        run_x_op("add stalled", ppc_pkg::xo_add, 5'd15, 5'd4, 5'd5);
        stall_cycles = 0;
        run_x_op("or after stall", ppc_pkg::xo_or, 5'd16, 5'd15, 5'd15);
    endtask

    task automatic test_unknown_opcode();
        send_instruction({6'd2, 5'd17, 5'd1, 16'h1234});
        repeat (10) begin
            @(negedge clk);
            check_value("unknown no result", 32'd0, 32'(result_valid));
        end
        check_value("unknown back to idle", 32'd1, 32'(instruction_ready));
        run_addi("addi after unknown", 5'd17, 5'd1, 16'h0042);
    endtask

    initial begin
        seed = 32'h450a;
        stall_cycles = 0;
        last_latency = 0;
        clk = 1'b0;
        rst = 1'b1;
        instruction_valid = 1'b0;
        instruction = 32'd0;
        result_ready = 1'b0;
        for (int i = 0; i < 32; i++) begin
            gpr_model[i] = 32'd0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_addi_after_reset();
        test_add_subf();
        test_logic_ops();
        test_mullw();
        test_back_pressure();
        test_unknown_opcode();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
